// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the byte buffer testbench with Verilator.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f src.f --top-module byte_buffer_tb \
      -Mdir obj_dir -o byte_buffer_sim; then
   echo "build failed"
   exit 1
fi

if ! ./obj_dir/byte_buffer_sim +verilator+error+limit+1000 > sim.log 2>&1; then
   cat sim.log
   echo "simulator returned an error status"
   exit 1
fi
cat sim.log

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
exit 0

// ==== src.f ====
src/bus_pkg.sv
src/mem_geom_pkg.sv
src/wb_write_port.sv
src/asym_converter.sv
src/banked_ram.sv
src/byte_buffer_top.sv
test/byte_buffer_assertions.sv
test/byte_buffer_tb.sv

// ==== src/asym_converter.sv ====
// Width converter between a 32-bit word write and an 8-bit byte read.
// Drives per-lane RAM enables and picks the read byte out of the lane word.

`timescale 1ns/1ns

module asym_converter #(
   parameter  int ADDR_W      = 8,
   parameter  int BIG_ENDIAN  = 0,
   localparam int WORD_ADDR_W = ADDR_W - mem_geom_pkg::LANE_SEL_W
) (
   input  logic                              clk_i,
   input  logic                              rst_i,

   // word write from the bus side
   input  logic                              w_en_i,
   input  logic [WORD_ADDR_W-1:0]            w_addr_i,
   input  logic [bus_pkg::WB_DATA_W-1:0]     w_data_i,
   input  bus_pkg::wb_sel_t                  w_sel_i,

   // byte read port, byte address
   input  logic                              r_en_i,
   input  logic [ADDR_W-1:0]                 r_addr_i,
   output logic [mem_geom_pkg::LANE_W-1:0]   r_data_o,

   // lane RAM write side
   output logic [mem_geom_pkg::LANES-1:0]    ext_mem_w_en_o,
   output logic [WORD_ADDR_W-1:0]            ext_mem_w_addr_o,
   output mem_geom_pkg::lane_word_u          ext_mem_w_data_o,

   // lane RAM read side
   output logic [mem_geom_pkg::LANES-1:0]    ext_mem_r_en_o,
   output logic [WORD_ADDR_W-1:0]            ext_mem_r_addr_o,
   input  mem_geom_pkg::lane_word_u          ext_mem_r_data_i
);

   import mem_geom_pkg::*;

   // physical lane addressed by the current read
   logic [LANE_SEL_W-1:0] r_lane;
   // lane of the last accepted read
   logic [LANE_SEL_W-1:0] r_lane_q;
   // high in the cycle right after a read
   logic                  r_valid_q;
   lane_word_u            r_word_q;
   lane_word_u            r_word;

   // write side
   // each byte select gates its own lane
   always_comb begin
      for (int k = 0; k < LANES; k++) begin
         ext_mem_w_en_o[k] = w_en_i & w_sel_i[k];
      end
   end

   assign ext_mem_w_addr_o      = w_addr_i;
   assign ext_mem_w_data_o.word = w_data_i;

   // read side
   // big endian puts byte 0 of a word in the top lane
   if (BIG_ENDIAN != 0) begin : g_big_endian
      assign r_lane = LANE_SEL_W'(LANES - 1) - r_addr_i[LANE_SEL_W-1:0];
   end else begin : g_little_endian
      assign r_lane = r_addr_i[LANE_SEL_W-1:0];
   end

   // only the addressed lane is read
   always_comb begin
      for (int k = 0; k < LANES; k++) begin
         ext_mem_r_en_o[k] = r_en_i && (r_lane == LANE_SEL_W'(k));
      end
   end

   assign ext_mem_r_addr_o = r_addr_i[ADDR_W-1:LANE_SEL_W];

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         r_valid_q <= 1'b0;
         r_lane_q  <= '0;
         r_word_q  <= '0;
      end else begin
         r_valid_q <= r_en_i;
         if (r_en_i) begin
            r_lane_q <= r_lane;
         end
         // capture the RAM word once it is valid so it survives later writes
         if (r_valid_q) begin
            r_word_q <= ext_mem_r_data_i;
         end
      end
   end

   // live RAM output right after a read, held copy from then on
   assign r_word = r_valid_q ? ext_mem_r_data_i : r_word_q;

   assign r_data_o = r_word.lane[r_lane_q];

endmodule

// ==== src/banked_ram.sv ====
// Storage RAM built from four byte-wide lanes.
// Every lane has its own write enable and registered, enabled read.

`timescale 1ns/1ns

module banked_ram #(
   parameter  int ADDR_W      = 8,
   localparam int WORD_ADDR_W = ADDR_W - mem_geom_pkg::LANE_SEL_W
) (
   input  logic                            clk_i,

   // write port, word address
   input  logic [mem_geom_pkg::LANES-1:0]  w_en_i,
   input  logic [WORD_ADDR_W-1:0]          w_addr_i,
   input  mem_geom_pkg::lane_word_u        w_data_i,

   // read port, word address
   input  logic [mem_geom_pkg::LANES-1:0]  r_en_i,
   input  logic [WORD_ADDR_W-1:0]          r_addr_i,
   output mem_geom_pkg::lane_word_u        r_data_o
);

   import mem_geom_pkg::*;

   localparam int DEPTH = 2 ** WORD_ADDR_W;

   // one byte array per lane
   logic [LANE_W-1:0] mem [LANES][DEPTH];

   // a lane without read enable keeps its last output
   always_ff @(posedge clk_i) begin
      for (int k = 0; k < LANES; k++) begin
         if (w_en_i[k]) begin
            mem[k][w_addr_i] <= w_data_i.lane[k];
         end
         if (r_en_i[k]) begin
            r_data_o.lane[k] <= mem[k][r_addr_i];
         end
      end
   end

endmodule

// ==== src/bus_pkg.sv ====
// Wishbone classic widths for the word-write port.
// Imported by the write port, the width converter and the top level.

package bus_pkg;

   // data bus width of the host port
   localparam int WB_DATA_W = 32;

   // one select bit per byte of the data bus
   localparam int WB_SEL_W = WB_DATA_W / 8;

   // byte-select vector as driven by the master
   typedef logic [WB_SEL_W-1:0] wb_sel_t;

endpackage

// ==== src/byte_buffer_top.sv ====
// Byte-read buffer with a Wishbone word-write port.
// Connects the write port, the width converter and the lane RAM.

`timescale 1ns/1ns

module byte_buffer_top #(
   parameter  int ADDR_W      = 8,
   parameter  int BIG_ENDIAN  = 0,
   localparam int WORD_ADDR_W = ADDR_W - mem_geom_pkg::LANE_SEL_W
) (
   input  logic                            clk_i,
   input  logic                            rst_i,

   // wishbone classic slave, word address
   input  logic                            wb_cyc_i,
   input  logic                            wb_stb_i,
   input  logic                            wb_we_i,
   input  logic [WORD_ADDR_W-1:0]          wb_adr_i,
   input  logic [bus_pkg::WB_DATA_W-1:0]   wb_dat_i,
   input  bus_pkg::wb_sel_t                wb_sel_i,
   output logic                            wb_ack_o,
   output logic                            wb_err_o,

   // byte read port
   input  logic                            r_en_i,
   input  logic [ADDR_W-1:0]               r_addr_i,
   output logic [mem_geom_pkg::LANE_W-1:0] r_data_o
);

   import bus_pkg::*;
   import mem_geom_pkg::*;

   logic                   w_en;
   logic [WORD_ADDR_W-1:0] w_addr;
   logic [WB_DATA_W-1:0]   w_data;
   wb_sel_t                w_sel;

   logic [LANES-1:0]       ext_mem_w_en;
   logic [WORD_ADDR_W-1:0] ext_mem_w_addr;
   lane_word_u             ext_mem_w_data;
   logic [LANES-1:0]       ext_mem_r_en;
   logic [WORD_ADDR_W-1:0] ext_mem_r_addr;
   lane_word_u             ext_mem_r_data;

   wb_write_port #(
      .ADDR_W(ADDR_W)
   ) u_wb_write_port (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .wb_cyc_i(wb_cyc_i),
      .wb_stb_i(wb_stb_i),
      .wb_we_i (wb_we_i),
      .wb_adr_i(wb_adr_i),
      .wb_dat_i(wb_dat_i),
      .wb_sel_i(wb_sel_i),
      .wb_ack_o(wb_ack_o),
      .wb_err_o(wb_err_o),
      .w_en_o  (w_en),
      .w_addr_o(w_addr),
      .w_data_o(w_data),
      .w_sel_o (w_sel)
   );

   asym_converter #(
      .ADDR_W    (ADDR_W),
      .BIG_ENDIAN(BIG_ENDIAN)
   ) u_asym_converter (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .w_en_i          (w_en),
      .w_addr_i        (w_addr),
      .w_data_i        (w_data),
      .w_sel_i         (w_sel),
      .r_en_i          (r_en_i),
      .r_addr_i        (r_addr_i),
      .r_data_o        (r_data_o),
      .ext_mem_w_en_o  (ext_mem_w_en),
      .ext_mem_w_addr_o(ext_mem_w_addr),
      .ext_mem_w_data_o(ext_mem_w_data),
      .ext_mem_r_en_o  (ext_mem_r_en),
      .ext_mem_r_addr_o(ext_mem_r_addr),
      .ext_mem_r_data_i(ext_mem_r_data)
   );

   banked_ram #(
      .ADDR_W(ADDR_W)
   ) u_banked_ram (
      .clk_i   (clk_i),
      .w_en_i  (ext_mem_w_en),
      .w_addr_i(ext_mem_w_addr),
      .w_data_i(ext_mem_w_data),
      .r_en_i  (ext_mem_r_en),
      .r_addr_i(ext_mem_r_addr),
      .r_data_o(ext_mem_r_data)
   );

endmodule

// ==== src/mem_geom_pkg.sv ====
// Geometry of the lane-split storage RAM.
// Shared by the width converter, the RAM and the top level.

package mem_geom_pkg;

   // a lane is one byte, which is also the read width
   localparam int LANE_W = 8;
   localparam int LANES = 4;

   // low byte-address bits that pick a lane
   localparam int LANE_SEL_W = $clog2(LANES);

   localparam int WORD_W = LANES * LANE_W;

   // a RAM word, seen either whole or lane by lane
   typedef union packed {
      logic [WORD_W-1:0]            word;
      logic [LANES-1:0][LANE_W-1:0] lane;
   } lane_word_u;

endpackage

// ==== src/wb_write_port.sv ====
// Wishbone classic slave for word writes into the buffer.
// Emits one write strobe per request; read cycles are ended with err.

`timescale 1ns/1ns

module wb_write_port #(
   parameter  int ADDR_W      = 8,
   localparam int WORD_ADDR_W = ADDR_W - mem_geom_pkg::LANE_SEL_W
) (
   input  logic                           clk_i,
   input  logic                           rst_i,

   // wishbone classic slave
   input  logic                           wb_cyc_i,
   input  logic                           wb_stb_i,
   input  logic                           wb_we_i,
   input  logic [WORD_ADDR_W-1:0]         wb_adr_i,
   input  logic [bus_pkg::WB_DATA_W-1:0]  wb_dat_i,
   input  bus_pkg::wb_sel_t               wb_sel_i,
   output logic                           wb_ack_o,
   output logic                           wb_err_o,

   // write strobe towards the converter
   output logic                           w_en_o,
   output logic [WORD_ADDR_W-1:0]         w_addr_o,
   output logic [bus_pkg::WB_DATA_W-1:0]  w_data_o,
   output bus_pkg::wb_sel_t               w_sel_o
);

   logic req;

   // new request only while no termination is pending
   // the master still holds stb in the ack cycle, so mask it there
   assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o;

   // write goes to the RAM on the same edge that raises ack
   assign w_en_o   = req & wb_we_i;
   assign w_addr_o = wb_adr_i;
   assign w_data_o = wb_dat_i;
   assign w_sel_o  = wb_sel_i;

   // one-cycle termination, ack for writes and err for reads
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wb_ack_o <= 1'b0;
         wb_err_o <= 1'b0;
      end else begin
         wb_ack_o <= req & wb_we_i;
         wb_err_o <= req & ~wb_we_i;
      end
   end

endmodule

// ==== test/byte_buffer_assertions.sv ====
// Checker bound to the byte buffer top level.
// Mirrors bus writes in a shadow memory and checks bus timing and read bytes.

`timescale 1ns/1ns

module byte_buffer_assertions #(
   parameter  int ADDR_W      = 8,
   localparam int WORD_ADDR_W = ADDR_W - mem_geom_pkg::LANE_SEL_W
) (
   input logic                            clk_i,
   input logic                            rst_i,
   input logic                            wb_cyc_i,
   input logic                            wb_stb_i,
   input logic                            wb_we_i,
   input logic [WORD_ADDR_W-1:0]          wb_adr_i,
   input logic [bus_pkg::WB_DATA_W-1:0]   wb_dat_i,
   input bus_pkg::wb_sel_t                wb_sel_i,
   input logic                            wb_ack_i,
   input logic                            wb_err_i,
   input logic                            r_en_i,
   input logic [ADDR_W-1:0]               r_addr_i,
   input logic [mem_geom_pkg::LANE_W-1:0] r_data_i
);

   import mem_geom_pkg::*;

   // lane k holds bits 8k+7 down to 8k of the bus word (little endian)
   logic [LANES-1:0][LANE_W-1:0] shadow [2**WORD_ADDR_W];
   logic [LANE_W-1:0]            exp_byte;
   logic [LANE_W-1:0]            last_data;
   logic                         read_seen;
   logic                         r_en_q;
   // high in the cycle where ack or err is expected
   logic                         req_w_q;
   logic                         req_r_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         read_seen <= 1'b0;
         req_w_q   <= 1'b0;
         req_r_q   <= 1'b0;
      end else begin
         if (r_en_i) begin
            read_seen <= 1'b1;
         end
         // a request counts as new only while no termination is expected
         req_w_q <= wb_cyc_i && wb_stb_i && wb_we_i && !req_w_q && !req_r_q;
         req_r_q <= wb_cyc_i && wb_stb_i && !wb_we_i && !req_w_q && !req_r_q;
      end
      r_en_q    <= r_en_i;
      last_data <= r_data_i;
      // the master still holds address, data and selects while ack is high
      if (wb_ack_i && wb_we_i) begin
         for (int k = 0; k < LANES; k++) begin
            if (wb_sel_i[k]) begin
               shadow[wb_adr_i][k] <= wb_dat_i[k*LANE_W +: LANE_W];
            end
         end
      end
      if (r_en_i) begin
         exp_byte <= shadow[r_addr_i[ADDR_W-1:LANE_SEL_W]][r_addr_i[LANE_SEL_W-1:0]];
      end
   end

   a_bus_term : assert property (@(posedge clk_i) disable iff (rst_i)
      wb_ack_i == req_w_q && wb_err_i == req_r_q)
      else begin
         $error("bus ack or err does not come exactly one cycle after its request");
         byte_buffer_tb.error_count = byte_buffer_tb.error_count + 1;
      end

   a_read_data : assert property (@(posedge clk_i) disable iff (rst_i)
      r_en_q |-> r_data_i == exp_byte)
      else begin
         $error("error read_data: expected %02h, got %02h", exp_byte, r_data_i);
         byte_buffer_tb.error_count = byte_buffer_tb.error_count + 1;
      end

   // zero until the first read, then the last byte read
   a_read_hold : assert property (@(posedge clk_i) disable iff (rst_i)
      !r_en_q |-> r_data_i == (read_seen ? last_data : '0))
      else begin
         $error("error read_hold: expected %02h, got %02h",
                read_seen ? last_data : '0, r_data_i);
         byte_buffer_tb.error_count = byte_buffer_tb.error_count + 1;
      end

endmodule

// ==== test/byte_buffer_tb.sv ====
// Testbench for the byte buffer: word writes over Wishbone, byte reads back.
// The bound checker judges the responses; this module reports the outcome.

`timescale 1ns/1ns

module byte_buffer_tb;

   import bus_pkg::*;
   import mem_geom_pkg::*;

   localparam int ADDR_W      = 8;
   localparam int WORD_ADDR_W = ADDR_W - LANE_SEL_W;
   localparam int TIMEOUT     = 16;

   logic                   clk_i;
   logic                   rst_i;
   logic                   wb_cyc_i;
   logic                   wb_stb_i;
   logic                   wb_we_i;
   logic [WORD_ADDR_W-1:0] wb_adr_i;
   logic [WB_DATA_W-1:0]   wb_dat_i;
   wb_sel_t                wb_sel_i;
   logic                   wb_ack_o;
   logic                   wb_err_o;
   logic                   r_en_i;
   logic [ADDR_W-1:0]      r_addr_i;
   logic [LANE_W-1:0]      r_data_o;

   // bumped by the bound checker on each failed assertion
   int     error_count   = 0;
   int     timeout_count = 0;
   integer seed          = 97;

   byte_buffer_top DUT (.*);

   bind byte_buffer_top byte_buffer_assertions #(.ADDR_W(ADDR_W)) u_checker (
      .wb_ack_i(wb_ack_o),
      .wb_err_i(wb_err_o),
      .r_data_i(r_data_o),
      .*
   );

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   // classic cycle, held through the edge that samples ack or err
   task automatic bus_cycle(input logic we, input logic [WORD_ADDR_W-1:0] adr,
                            input logic [WB_DATA_W-1:0] dat, input wb_sel_t sel);
      int waited = 0;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = dat;
      wb_sel_i = sel;
      @(posedge clk_i);
      #1;
      while (!wb_ack_o && !wb_err_o && waited < TIMEOUT) begin
         @(posedge clk_i);
         #1;
         waited++;
      end
      if (!wb_ack_o && !wb_err_o) begin
         $display("timeout: bus cycle to word %0h got neither ack nor err", adr);
         timeout_count++;
      end else begin
         @(posedge clk_i);
         #1;
      end
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   // r_en_i for one cycle, the byte follows in the next cycle
   task automatic read_byte(input logic [ADDR_W-1:0] addr);
      r_en_i   = 1'b1;
      r_addr_i = addr;
      @(posedge clk_i);
      #1;
      r_en_i = 1'b0;
   endtask

   task automatic read_word_bytes(input logic [WORD_ADDR_W-1:0] adr);
      for (int k = 0; k < LANES; k++) begin
         read_byte({adr, LANE_SEL_W'(k)});
      end
   endtask

   initial begin
      logic [WORD_ADDR_W-1:0] adr;
      logic [WORD_ADDR_W-1:0] written [$];
      rst_i    = 1'b1;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      wb_adr_i = '0;
      wb_dat_i = '0;
      wb_sel_i = '0;
      r_en_i   = 1'b0;
      r_addr_i = '0;
      repeat (8) @(posedge clk_i);
      #1;
      rst_i = 1'b0;
      repeat (3) @(posedge clk_i);
      #1;

      // full-word writes, each followed by reads of all four bytes
      for (int n = 0; n < 12; n++) begin
         adr = WORD_ADDR_W'($random(seed));
         written.push_back(adr);
         bus_cycle(1'b1, adr, $random(seed), '1);
         read_word_bytes(adr);
      end

      // partial writes leave the unselected bytes alone
      foreach (written[n]) begin
         bus_cycle(1'b1, written[n], $random(seed), wb_sel_t'($random(seed)));
         read_word_bytes(written[n]);
      end

      // bus reads end with err
      for (int n = 0; n < 3; n++) begin
         bus_cycle(1'b0, written[n], '0, '1);
      end

      // the read byte holds while the same word is rewritten
      read_byte({written[0], LANE_SEL_W'(2)});
      bus_cycle(1'b1, written[0], $random(seed), '1);
      bus_cycle(1'b1, written[1], $random(seed), '1);
      repeat (4) @(posedge clk_i);
      #1;
      read_word_bytes(written[0]);
      repeat (4) @(posedge clk_i);

      $display("totals: %0d failed checks, %0d timeouts", error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
